/* rtl/wcache_cfg.svh */
//==========================================================================
// Size macros for the weight cache
//==========================================================================
`ifndef WCACHE_CFG_SVH
`define WCACHE_CFG_SVH

// PE-row ports sharing the single WRAM read port
`define WC_PORTS 4

// WRAM address width
`define WC_AW 13

// Weight width
`define WC_DW 8

// Hit-array entries, fully associative
`define WC_HIT_LEN 8

`endif

/* rtl/wcache_pkg.sv */
//==========================================================================
// Weight cache types
// Request, data, WRAM read and hit-entry structs, control states
//==========================================================================
`default_nettype none
`include "wcache_cfg.svh"

package wcache_pkg;

    typedef struct packed {
        logic [`WC_AW-1:0] add;
        logic              lst;
    } port_req_t;

    typedef struct packed {
        logic [`WC_DW-1:0] dat;
        logic              lst;
    } port_dat_t;

    // Read address tagged with the requesting port
    typedef struct packed {
        logic [`WC_AW-1:0]           add;
        logic                        lst;
        logic [$clog2(`WC_PORTS)-1:0] idx;
    } wram_req_t;

    typedef struct packed {
        logic [`WC_AW-1:0] add;
        logic [`WC_DW-1:0] dat;
        logic              vld;
    } hit_entry_t;

    typedef enum logic [1:0] {IDLE, CFG, WORK} wc_state_e;

endpackage

`default_nettype wire

/* rtl/wcache_ctrl.sv */
//==========================================================================
// Configuration FSM and mode latch
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module wcache_ctrl
    import wcache_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_info_vld,
    input  logic cfg_wbuf_ena,
    output logic cfg_info_rdy,
    output logic work,
    output logic cached,
    output logic clear
);

    wc_state_e state;
    wc_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (cfg_info_vld) state_nxt = CFG;
            CFG:     state_nxt = WORK;
            WORK:    if (cfg_info_vld) state_nxt = IDLE; // Back to idle, cache flushed
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Mode sampled on the way into WORK
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cached <= 1'b0;
        end else if (state == CFG) begin
            cached <= cfg_wbuf_ena;
        end
    end

    assign cfg_info_rdy = (state == IDLE);
    assign work         = (state == WORK);
    assign clear        = (state != WORK); // Flush while not working

endmodule

`default_nettype wire

/* rtl/hold_stage.sv */
//==========================================================================
// One-entry valid/ready holding register, any payload type
//==========================================================================
`default_nettype none
`timescale 1ns/1ps

module hold_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  logic     in_vld,
    output logic     in_rdy,
    input  payload_t in,
    output logic     out_vld,
    input  logic     out_rdy,
    output payload_t out
);

    assign in_rdy = !out_vld || out_rdy; // Empty or draining

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else if (clear) begin
            out_vld <= 1'b0;
        end else if (in_rdy) begin
            out_vld <= in_vld;
        end
    end

    // Payload keeps its value after the transfer
    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            out <= in;
        end
    end

endmodule

`default_nettype wire

/* rtl/hit_lookup.sv */
//==========================================================================
// Per-port address decode into hit array hit, last-access hit or miss
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module hit_lookup
    import wcache_pkg::*;
(
    input  logic                            work,
    input  logic                            cached,
    input  logic                            req_vld,
    input  port_req_t                       req,
    input  hit_entry_t [`WC_HIT_LEN-1:0]    entries,
    input  hit_entry_t                      last,
    input  logic                            slot_free,
    input  logic                            grant,
    output logic                            hit,
    output port_dat_t                       hit_dat,
    output logic                            miss_vld,
    output logic                            req_rdy
);

    logic              ent_hit;
    logic [`WC_DW-1:0] ent_dat;
    logic              last_hit;
    logic              found;

    // Lowest matching entry wins
    always_comb begin
        ent_hit = 1'b0;
        ent_dat = '0;
        for (int i = 0; i < `WC_HIT_LEN; i++) begin
            if (!ent_hit && entries[i].vld && entries[i].add == req.add) begin
                ent_hit = 1'b1;
                ent_dat = entries[i].dat;
            end
        end
    end

    assign last_hit = last.vld && (last.add == req.add);
    assign found    = work && cached && (ent_hit || last_hit); // Never in bypass

    assign hit_dat.dat = ent_hit ? ent_dat : last.dat;
    assign hit_dat.lst = req.lst;

    assign hit      = req_vld && found && slot_free;
    assign miss_vld = work && req_vld && !found;

    // Misses complete on the WRAM return routed to this port
    assign req_rdy  = work && slot_free && (found || grant);

endmodule

`default_nettype wire

/* rtl/hit_store.sv */
//==========================================================================
// Hit array with round-robin fill pointer
// Last-access register
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module hit_store
    import wcache_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            clear,
    input  logic                            cached,
    input  logic                            fill_vld,
    input  port_dat_t                       fill,
    input  logic [`WC_AW-1:0]               fill_add,
    output hit_entry_t [`WC_HIT_LEN-1:0]    entries,
    output hit_entry_t                      last
);

    localparam int HW = $clog2(`WC_HIT_LEN);

    logic [HW-1:0] fill_ptr;
    logic          dup;

    // Address already cached somewhere
    always_comb begin
        dup = 1'b0;
        for (int i = 0; i < `WC_HIT_LEN; i++) begin
            if (entries[i].vld && entries[i].add == fill_add) begin
                dup = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entries  <= '0;
            last     <= '0;
            fill_ptr <= '0;
        end else if (clear) begin
            entries  <= '0;
            last     <= '0;
            fill_ptr <= '0;
        end else if (fill_vld) begin
            last <= '{add: fill_add, dat: fill.dat, vld: 1'b1};
            if (cached && !dup) begin
                entries[fill_ptr] <= '{add: fill_add, dat: fill.dat, vld: 1'b1};
                fill_ptr          <= fill_ptr + 1'b1; // Oldest entry overwritten next
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/wram_fetch.sv */
//==========================================================================
// Round-robin miss arbiter, WRAM read request and return routing
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module wram_fetch
    import wcache_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            work,
    input  logic [`WC_PORTS-1:0]            miss_vld,
    input  port_req_t [`WC_PORTS-1:0]       miss_req,
    output logic [`WC_PORTS-1:0]            grant,
    output logic                            wram_add_vld,
    output port_req_t                       wram_add,
    input  logic                            wram_add_rdy,
    input  logic                            wram_dat_vld,
    input  port_dat_t                       wram_dat,
    output logic                            wram_dat_rdy,
    input  logic [`WC_PORTS-1:0]            port_free,
    output logic [`WC_PORTS-1:0]            ret_vld,
    output port_dat_t                       ret_dat
);

    localparam int PW = $clog2(`WC_PORTS);

    logic [PW-1:0] rr_last;
    logic [PW-1:0] pick_idx;
    logic [PW-1:0] pend_idx;
    logic          pick_vld;
    logic          pend;
    logic          ld_vld;
    logic          ld_rdy;
    wram_req_t     pick_req;
    wram_req_t     out_req;

    //======================================================================
    // Arbitration, search starts after the last winner
    //======================================================================
    always_comb begin
        int c;
        pick_vld = 1'b0;
        pick_idx = rr_last;
        for (int i = 1; i <= `WC_PORTS; i++) begin
            c = (int'(rr_last) + i) % `WC_PORTS;
            if (!pick_vld && miss_vld[c]) begin
                pick_vld = 1'b1;
                pick_idx = PW'(c);
            end
        end
    end

    assign pick_req = '{add: miss_req[pick_idx].add, lst: miss_req[pick_idx].lst,
                        idx: pick_idx};
    assign ld_vld   = work && pick_vld && !pend && !wram_add_vld; // One read at a time

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_last <= '0;
        end else if (ld_vld && ld_rdy) begin
            rr_last <= pick_idx;
        end
    end

    // Request held here while the WRAM stalls; a posted read always completes
    hold_stage #(
        .payload_t (wram_req_t)
    ) req_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (1'b0),
        .in_vld  (ld_vld),
        .in_rdy  (ld_rdy),
        .in      (pick_req),
        .out_vld (wram_add_vld),
        .out_rdy (wram_add_rdy),
        .out     (out_req)
    );

    assign wram_add = '{add: out_req.add, lst: out_req.lst};

    //======================================================================
    // Outstanding read and return routing
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            pend_idx <= '0;
        end else if (wram_add_vld && wram_add_rdy) begin
            pend     <= 1'b1;
            pend_idx <= out_req.idx;
        end else if (wram_dat_rdy) begin
            pend     <= 1'b0;
        end
    end

    // Ready only offered against a valid return; sunk when not working
    assign wram_dat_rdy = wram_dat_vld && pend && (port_free[pend_idx] || !work);

    always_comb begin
        for (int p = 0; p < `WC_PORTS; p++) begin
            ret_vld[p] = work && wram_dat_rdy && (pend_idx == PW'(p));
        end
    end

    assign grant   = ret_vld; // Port address taken with its data
    assign ret_dat = wram_dat;

endmodule

`default_nettype wire

/* rtl/port_result.sv */
//==========================================================================
// Per-port result stage, merges held hit data with WRAM return data
//==========================================================================
`default_nettype none
`timescale 1ns/1ps

module port_result
    import wcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  logic      hit,
    input  port_dat_t hit_dat,
    input  logic      ret_vld,
    input  port_dat_t ret_dat,
    output logic      dat_vld,
    input  logic      dat_rdy,
    output port_dat_t dat,
    output logic      free
);

    logic      ret_pass;
    logic      stg_in_vld;
    logic      stg_out_vld;
    port_dat_t stg_in;
    port_dat_t stg_out;

    // Return bypasses the register when nothing older is held
    assign ret_pass = ret_vld && !stg_out_vld;

    // Park a return that cannot leave this cycle
    assign stg_in_vld = hit || (ret_vld && !(ret_pass && dat_rdy));
    assign stg_in     = ret_vld ? ret_dat : hit_dat;

    hold_stage #(
        .payload_t (port_dat_t)
    ) dat_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .in_vld  (stg_in_vld),
        .in_rdy  (free),
        .in      (stg_in),
        .out_vld (stg_out_vld),
        .out_rdy (dat_rdy),
        .out     (stg_out)
    );

    assign dat     = ret_pass ? ret_dat : stg_out;
    assign dat_vld = !clear && (ret_pass || stg_out_vld);

endmodule

`default_nettype wire

/* rtl/weight_cache.sv */
//==========================================================================
// Weight cache top level
// Control, hit array, per-port lookup and result, WRAM fetch
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module weight_cache
    import wcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_info_vld,
    output logic                        cfg_info_rdy,
    input  logic                        cfg_wbuf_ena,
    input  logic [`WC_PORTS-1:0]        ptow_add_vld,
    output logic [`WC_PORTS-1:0]        ptow_add_rdy,
    input  port_req_t [`WC_PORTS-1:0]   ptow_add,
    output logic [`WC_PORTS-1:0]        ptow_dat_vld,
    input  logic [`WC_PORTS-1:0]        ptow_dat_rdy,
    output port_dat_t [`WC_PORTS-1:0]   ptow_dat,
    output logic                        wram_add_vld,
    input  logic                        wram_add_rdy,
    output port_req_t                   wram_add,
    input  logic                        wram_dat_vld,
    output logic                        wram_dat_rdy,
    input  port_dat_t                   wram_dat
);

    logic                           work;
    logic                           cached;
    logic                           clear;
    hit_entry_t [`WC_HIT_LEN-1:0]   entries;
    hit_entry_t                     last;
    logic [`WC_PORTS-1:0]           hit;
    port_dat_t [`WC_PORTS-1:0]      hit_dat;
    logic [`WC_PORTS-1:0]           miss_vld;
    logic [`WC_PORTS-1:0]           grant;
    logic [`WC_PORTS-1:0]           ret_vld;
    port_dat_t                      ret_dat;
    logic [`WC_PORTS-1:0]           port_free;

    wcache_ctrl wcache_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_info_vld (cfg_info_vld),
        .cfg_wbuf_ena (cfg_wbuf_ena),
        .cfg_info_rdy (cfg_info_rdy),
        .work         (work),
        .cached       (cached),
        .clear        (clear)
    );

    // Filled from every accepted WRAM return
    hit_store hit_store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .cached   (cached),
        .fill_vld (wram_dat_rdy),
        .fill     (wram_dat),
        .fill_add (wram_add.add),
        .entries  (entries),
        .last     (last)
    );

    wram_fetch wram_fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .work         (work),
        .miss_vld     (miss_vld),
        .miss_req     (ptow_add),
        .grant        (grant),
        .wram_add_vld (wram_add_vld),
        .wram_add     (wram_add),
        .wram_add_rdy (wram_add_rdy),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat     (wram_dat),
        .wram_dat_rdy (wram_dat_rdy),
        .port_free    (port_free),
        .ret_vld      (ret_vld),
        .ret_dat      (ret_dat)
    );

    for (genvar p = 0; p < `WC_PORTS; p++) begin : g_port
        hit_lookup hit_lookup_i (
            .work      (work),
            .cached    (cached),
            .req_vld   (ptow_add_vld[p]),
            .req       (ptow_add[p]),
            .entries   (entries),
            .last      (last),
            .slot_free (port_free[p]),
            .grant     (grant[p]),
            .hit       (hit[p]),
            .hit_dat   (hit_dat[p]),
            .miss_vld  (miss_vld[p]),
            .req_rdy   (ptow_add_rdy[p])
        );

        port_result port_result_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .clear   (clear),
            .hit     (hit[p]),
            .hit_dat (hit_dat[p]),
            .ret_vld (ret_vld[p]),
            .ret_dat (ret_dat),
            .dat_vld (ptow_dat_vld[p]),
            .dat_rdy (ptow_dat_rdy[p]),
            .dat     (ptow_dat[p]),
            .free    (port_free[p])
        );
    end

endmodule

`default_nettype wire

/* verif/weight_cache_asserts.sv */
//==========================================================================
// Concurrent checks on the weight cache
// WRAM request stability, single outstanding read, idle port outputs
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module weight_cache_asserts
    import wcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_info_vld,
    input  logic [`WC_PORTS-1:0]    ptow_dat_vld,
    input  logic                    wram_add_vld,
    input  logic                    wram_add_rdy,
    input  port_req_t               wram_add,
    input  logic                    wram_dat_vld,
    input  logic                    wram_dat_rdy
);

    logic      outst; // WRAM read accepted and its data not yet taken
    wc_state_e st_m;  // Control state rebuilt from the configuration handshake

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outst <= 1'b0;
        end else if (wram_add_vld && wram_add_rdy) begin
            outst <= 1'b1;
        end else if (wram_dat_vld && wram_dat_rdy) begin
            outst <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_m <= IDLE;
        end else begin
            case (st_m)
                IDLE:    if (cfg_info_vld) st_m <= CFG;
                CFG:     st_m <= WORK;
                WORK:    if (cfg_info_vld) st_m <= IDLE;
                default: st_m <= IDLE;
            endcase
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wram_add_vld && !wram_add_rdy |=> wram_add_vld && $stable(wram_add))
        else $error("WRAM request dropped or changed while stalled");

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        st_m != WORK |-> ptow_dat_vld == '0)
        else $error("Port data valid outside WORK");

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        wram_add_vld && wram_add_rdy |-> !outst)
        else $error("Second WRAM read issued while one is outstanding");

endmodule

`default_nettype wire

/* verif/tb_weight_cache.sv */
//==========================================================================
// Weight cache testbench
// LFSR port traffic, WRAM model, per-port expected data queues
//==========================================================================
`default_nettype none
`timescale 1ns/1ps
`include "wcache_cfg.svh"

module tb_weight_cache
    import wcache_pkg::*;
();

    localparam int NP  = `WC_PORTS;
    localparam int TMO = 5000;              // Cycles allowed for any wait

    logic               clk;
    logic               rst_n;
    logic               cfg_info_vld;
    logic               cfg_info_rdy;
    logic               cfg_wbuf_ena;
    logic [NP-1:0]      ptow_add_vld;
    logic [NP-1:0]      ptow_add_rdy;
    port_req_t [NP-1:0] ptow_add;
    logic [NP-1:0]      ptow_dat_vld;
    logic [NP-1:0]      ptow_dat_rdy;
    port_dat_t [NP-1:0] ptow_dat;
    logic               wram_add_vld;
    logic               wram_add_rdy;
    port_req_t          wram_add;
    logic               wram_dat_vld;
    logic               wram_dat_rdy;
    port_dat_t          wram_dat;

    logic [31:0]        lfsr;
    port_req_t          req_q [NP][$];      // Addresses still to send
    port_dat_t          exp_q [NP][$];      // Expected data in port order
    logic               rand_gaps;
    logic               rand_rdy;
    logic               chk_hit_lat;
    logic               exp_work;
    logic               cfg_xfer;
    logic               cfg_rdy_s;
    logic [NP-1:0]      acc_now;
    logic [NP-1:0]      hit_due;
    int                 wram_reqs;
    int                 accepted;
    logic               wm_busy;            // WRAM model holds a read
    port_req_t          wm_req;
    int                 wm_wait;

    weight_cache weight_cache_i (.*);

    bind weight_cache weight_cache_asserts weight_cache_asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_info_vld (cfg_info_vld),
        .ptow_dat_vld (ptow_dat_vld),
        .wram_add_vld (wram_add_vld),
        .wram_add_rdy (wram_add_rdy),
        .wram_add     (wram_add),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat_rdy (wram_dat_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //======================================================================
    // Random source, memory contents and reporting
    //======================================================================
    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003; // Galois taps 32,22,2,1
        return b;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(rand_bit());
        end
        return v;
    endfunction

    // WRAM contents with every address bit mixed in
    function automatic logic [`WC_DW-1:0] weight_of(logic [`WC_AW-1:0] add);
        return add[7:0] ^ {add[12:8], 3'b011} ^ 8'h96;
    endfunction

    function automatic logic [`WC_AW-1:0] pool_add(int idx);
        return `WC_AW'(idx * 'h1a3 + 'h047);
    endfunction

    task automatic abort(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(logic [31:0] act, logic [31:0] exp, string msg);
        if (act !== exp) begin
            abort($sformatf("Mismatch at %0t ns: %s, got %0h expected %0h",
                            $time, msg, act, exp));
        end
    endtask

    //======================================================================
    // One clock cycle that samples at the falling edge and drives after the rising one
    //======================================================================
    task automatic step();
        port_dat_t d;
        @(negedge clk);
        cfg_xfer  = cfg_info_vld && cfg_info_rdy;
        cfg_rdy_s = cfg_info_rdy;
        if (exp_work) check(cfg_info_rdy, 0, "cfg_info_rdy while configured");
        for (int p = 0; p < NP; p++) begin
            acc_now[p] = ptow_add_vld[p] && ptow_add_rdy[p];
            if (acc_now[p]) begin
                d.dat = weight_of(ptow_add[p].add);
                d.lst = ptow_add[p].lst;
                exp_q[p].push_back(d);
                accepted++;
            end
            if (chk_hit_lat && hit_due[p]) begin
                check(ptow_dat_vld[p], 1, $sformatf("port %0d hit data latency", p));
            end
            hit_due[p] = acc_now[p];
            if (ptow_dat_vld[p] && ptow_dat_rdy[p]) begin
                if (exp_q[p].size() == 0) begin
                    abort($sformatf("Port %0d delivered data nobody asked for", p));
                end
                check(ptow_dat[p], exp_q[p].pop_front(), $sformatf("port %0d data", p));
            end
        end
        if (wram_dat_vld && wram_dat_rdy) wm_busy = 1'b0;
        if (wram_add_vld && wram_add_rdy) begin
            if (wm_busy) abort("WRAM read accepted while another was still open");
            wm_busy = 1'b1;
            wm_req  = wram_add;
            wm_wait = 1 + rand_bits(2);     // 1 to 4 cycles
            wram_reqs++;
        end
        @(posedge clk);
        #10;
        for (int p = 0; p < NP; p++) begin
            if (acc_now[p] || !ptow_add_vld[p]) begin
                ptow_add_vld[p] = 1'b0;
                if (req_q[p].size() != 0 && (!rand_gaps || rand_bit())) begin
                    ptow_add[p]     = req_q[p].pop_front();
                    ptow_add_vld[p] = 1'b1;
                end
            end
            ptow_dat_rdy[p] = rand_rdy ? (rand_bit() | rand_bit()) : 1'b1;
        end
        wram_add_rdy = rand_rdy ? rand_bit() : 1'b1;
        if (!wm_busy) begin
            wram_dat_vld = 1'b0;
        end else if (!wram_dat_vld) begin
            if (wm_wait > 1) begin
                wm_wait--;
            end else begin
                wram_dat_vld = 1'b1;
                wram_dat.dat = weight_of(wm_req.add);
                wram_dat.lst = wm_req.lst;
            end
        end
    endtask

    function automatic logic drained();
        for (int p = 0; p < NP; p++) begin
            if (req_q[p].size() != 0 || exp_q[p].size() != 0) return 1'b0;
        end
        return !wm_busy && !wram_add_vld && ptow_add_vld == '0;
    endfunction

    task automatic wait_drain(string what);
        int n;
        n = 0;
        while (!drained()) begin
            if (n == TMO) abort({"Timed out waiting for ", what, " traffic to finish"});
            step();
            n++;
        end
    endtask

    task automatic configure(logic mode);
        int n;
        n            = 0;
        cfg_wbuf_ena = mode;
        cfg_info_vld = 1'b1;
        cfg_xfer     = 1'b0;
        while (!cfg_xfer) begin
            if (n == TMO) abort("Timed out waiting for the configuration handshake");
            step();
            n++;
        end
        cfg_info_vld = 1'b0;
        exp_work     = 1'b1; // Ready stays low through CFG and WORK
    endtask

    task automatic release_cfg();
        cfg_info_vld = 1'b1;
        step();
        cfg_info_vld = 1'b0;
        exp_work     = 1'b0;
        step();
        check(cfg_rdy_s, 1, "cfg_info_rdy back in IDLE");
    endtask

    task automatic load_random(int n);
        port_req_t r;
        for (int p = 0; p < NP; p++) begin
            for (int i = 0; i < n; i++) begin
                r.add = pool_add(rand_bits(4) % 12);
                r.lst = rand_bit();
                req_q[p].push_back(r);
            end
        end
    endtask

    //======================================================================
    // Test sequence
    //======================================================================
    initial begin
        port_req_t rep;
        int        base_req;
        int        base_acc;
        lfsr         = 32'h6abf_f426;
        rst_n        = 1'b0;
        cfg_info_vld = 1'b0;
        cfg_wbuf_ena = 1'b0;
        ptow_add_vld = '0;
        ptow_add     = '0;
        ptow_dat_rdy = '0;
        wram_add_rdy = 1'b0;
        wram_dat_vld = 1'b0;
        wram_dat     = '0;
        rand_gaps    = 1'b0;
        rand_rdy     = 1'b0;
        chk_hit_lat  = 1'b0;
        exp_work     = 1'b0;
        acc_now      = '0;
        hit_due      = '0;
        wram_reqs    = 0;
        accepted     = 0;
        wm_busy      = 1'b0;
        wm_wait      = 0;
        repeat (3) @(posedge clk);
        #10 rst_n = 1'b1;
        @(negedge clk);
        check(cfg_info_rdy, 1, "cfg_info_rdy after reset");
        check(ptow_add_rdy, 0, "ptow_add_rdy after reset");
        check(ptow_dat_vld, 0, "ptow_dat_vld after reset");
        check(wram_add_vld, 0, "wram_add_vld after reset");
        check(wram_dat_rdy, 0, "wram_dat_rdy after reset");
        @(posedge clk);
        #10;

        // Bypass mode reads the WRAM once per accepted address
        configure(1'b0);
        rand_gaps = 1'b1;
        rand_rdy  = 1'b1;
        base_req  = wram_reqs;
        base_acc  = accepted;
        load_random(12);
        wait_drain("bypass");
        check(wram_reqs - base_req, accepted - base_acc, "WRAM reads in bypass");
        release_cfg();

        // Cached mode with random traffic under back-pressure
        configure(1'b1);
        load_random(24);
        wait_drain("cached");

        // One fetch on port 0 and then hits on every port
        rand_gaps = 1'b0;
        rand_rdy  = 1'b0;
        rep.add   = `WC_AW'('h1abc);        // Outside the random pool
        rep.lst   = 1'b1;
        base_req  = wram_reqs;
        req_q[0].push_back(rep);
        wait_drain("first fetch");
        check(wram_reqs - base_req, 1, "WRAM reads for first fetch");
        chk_hit_lat = 1'b1;
        hit_due     = '0;                   // Only the repeats count as hits
        for (int p = 0; p < NP; p++) begin
            req_q[p].push_back(rep);
        end
        wait_drain("repeated address");
        chk_hit_lat = 1'b0;
        check(wram_reqs - base_req, 1, "WRAM reads after repeats");

        // New configuration starts with an empty cache
        release_cfg();
        configure(1'b1);
        base_req = wram_reqs;
        req_q[0].push_back(rep);
        wait_drain("refetch");
        check(wram_reqs - base_req, 1, "WRAM reads after cache clear");

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* weight_cache.f */
+incdir+rtl
rtl/wcache_pkg.sv
rtl/wcache_ctrl.sv
rtl/hold_stage.sv
rtl/hit_lookup.sv
rtl/hit_store.sv
rtl/wram_fetch.sv
rtl/port_result.sv
rtl/weight_cache.sv
verif/weight_cache_asserts.sv
verif/tb_weight_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the weight cache testbench, result taken from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_weight_cache \
    -f weight_cache.f -Mdir obj_dir &&
./obj_dir/Vtb_weight_cache > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
